/* md_div_long.sv */
`timescale 1ns/1ps
`default_nettype none

module md_div_long import md_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             en_i,
  input  md_req_t          req_i,
  input  logic             ready_i,
  input  logic [IMD_W-1:0] imd0_i,
  input  logic [IMD_W-1:0] imd1_i,
  input  logic [XLEN+1:0]  adder_sum_i,
  output logic [XLEN:0]    adder_a_o,
  output logic [XLEN:0]    adder_b_o,
  output imd_wr_t          imd0_wr_o,
  output imd_wr_t          imd1_wr_o,
  output logic             valid_o
);

  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } div_state_e;

  div_state_e       div_state_q;
  div_state_e       div_state_d;
  logic             is_div;
  logic             is_quot;
  logic             div_hold;
  logic             div_en;
  logic [4:0]       div_counter_q;
  logic [4:0]       div_counter_d;
  logic [XLEN-1:0]  numerator_q;
  logic [XLEN-1:0]  numerator_d;
  logic [XLEN-1:0]  quotient_q;
  logic [XLEN-1:0]  quotient_d;
  logic [XLEN-1:0]  denominator_q;
  logic [XLEN-1:0]  denominator_d;
  logic [IMD_W-1:0] remainder_d;
  logic             by_zero_q;
  logic             by_zero_d;
  logic             equal_to_zero;
  logic [XLEN-1:0]  res_adder_h;
  logic [XLEN-1:0]  next_remainder;
  logic [XLEN-1:0]  next_quotient;
  logic [XLEN-1:0]  one_shift;
  logic             is_greater_equal;
  logic             sign_a;
  logic             sign_b;
  logic             div_change_sign;
  logic             rem_change_sign;

  assign is_div  = (req_i.operator == MD_OP_DIV) || (req_i.operator == MD_OP_REM);
  assign is_quot = (req_i.operator == MD_OP_DIV);

  // upper word of the extended sum is the true a + b
  assign res_adder_h   = adder_sum_i[XLEN:1];
  assign equal_to_zero = (res_adder_h == '0);
  assign denominator_q = imd1_i[XLEN-1:0];

  assign one_shift      = {{(XLEN-1){1'b0}}, 1'b1} << div_counter_q;
  assign next_remainder = is_greater_equal ? res_adder_h : imd0_i[XLEN-1:0];
  assign next_quotient  = is_greater_equal ? (quotient_q | one_shift) : quotient_q;

  // trial subtraction of the denominator where a sign compare replaces a 33rd bit
  always_comb begin
    if ((imd0_i[XLEN-1] ^ denominator_q[XLEN-1]) == 1'b0) begin
      is_greater_equal = ~res_adder_h[XLEN-1];
    end else begin
      is_greater_equal = imd0_i[XLEN-1];
    end
  end

  assign sign_a          = req_i.op_a[XLEN-1] & req_i.sign.a_signed;
  assign sign_b          = req_i.op_b[XLEN-1] & req_i.sign.b_signed;
  assign div_change_sign = (sign_a ^ sign_b) & ~by_zero_q;
  assign rem_change_sign = sign_a;

  always_comb begin
    div_state_d   = div_state_q;
    div_counter_d = div_counter_q - 5'd1;
    numerator_d   = numerator_q;
    quotient_d    = quotient_q;
    denominator_d = denominator_q;
    remainder_d   = imd0_i;
    by_zero_d     = by_zero_q;
    div_hold      = 1'b0;
    // default adder use is 0 - op_b
    adder_a_o     = {{XLEN{1'b0}}, 1'b1};
    adder_b_o     = {~req_i.op_b, 1'b1};
    unique case (div_state_q)
      IDLE: begin
        // divide by zero gives all ones or the dividend
        if (is_quot) begin
          remainder_d = '1;
        end else begin
          remainder_d = {2'b0, req_i.op_a};
        end
        by_zero_d     = equal_to_zero;
        div_state_d   = equal_to_zero ? FINISH : ABS_A;
        div_counter_d = 5'd31;
      end
      ABS_A: begin
        quotient_d    = '0;
        numerator_d   = sign_a ? res_adder_h : req_i.op_a;
        div_counter_d = 5'd31;
        adder_b_o     = {~req_i.op_a, 1'b1};
        div_state_d   = ABS_B;
      end
      ABS_B: begin
        // seed the partial remainder with the top numerator bit
        remainder_d   = {{(IMD_W-1){1'b0}}, numerator_q[XLEN-1]};
        denominator_d = sign_b ? res_adder_h : req_i.op_b;
        div_counter_d = 5'd31;
        div_state_d   = COMP;
      end
      COMP: begin
        remainder_d = {1'b0, next_remainder, numerator_q[div_counter_d]};
        quotient_d  = next_quotient;
        adder_a_o   = {imd0_i[XLEN-1:0], 1'b1};
        adder_b_o   = {~denominator_q, 1'b1};
        div_state_d = (div_counter_q == 5'd1) ? LAST : COMP;
      end
      LAST: begin
        // last step keeps only what the operator returns
        if (is_quot) begin
          remainder_d = {2'b0, next_quotient};
        end else begin
          remainder_d = {2'b0, next_remainder};
        end
        adder_a_o   = {imd0_i[XLEN-1:0], 1'b1};
        adder_b_o   = {~denominator_q, 1'b1};
        div_state_d = CHANGE_SIGN;
      end
      CHANGE_SIGN: begin
        if (is_quot ? div_change_sign : rem_change_sign) begin
          remainder_d = {2'b0, res_adder_h};
        end
        adder_b_o   = {~imd0_i[XLEN-1:0], 1'b1};
        div_state_d = FINISH;
      end
      FINISH: begin
        div_hold    = ~ready_i;
        div_state_d = IDLE;
      end
      default: begin
        div_state_d = IDLE;
      end
    endcase
  end

  assign div_en    = en_i & is_div & ~div_hold;
  assign valid_o   = (div_state_q == FINISH);
  assign imd0_wr_o = '{we: div_en, data: remainder_d};
  assign imd1_wr_o = '{we: div_en, data: {2'b0, denominator_d}};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_state_q   <= IDLE;
      div_counter_q <= '0;
      numerator_q   <= '0;
      quotient_q    <= '0;
      by_zero_q     <= 1'b0;
    end else if (div_en) begin
      div_state_q   <= div_state_d;
      div_counter_q <= div_counter_d;
      numerator_q   <= numerator_d;
      quotient_q    <= quotient_d;
      by_zero_q     <= by_zero_d;
    end
  end

  counter_no_wrap_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    div_state_q == COMP |-> div_counter_q != 5'd0);

  // the result only appears after the sign fix-up or on a zero divisor
  valid_in_finish_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(valid_o) |-> ($past(div_state_q) == CHANGE_SIGN) || by_zero_q);

endmodule

`default_nettype wire

/* md_mult_fast.sv */
`timescale 1ns/1ps
`default_nettype none

module md_mult_fast import md_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             en_i,
  input  md_req_t          req_i,
  input  logic             ready_i,
  input  logic [IMD_W-1:0] imd0_i,
  output imd_wr_t          imd0_wr_o,
  output logic [XLEN-1:0]  mult_res_o,
  output logic             valid_o
);

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e             mult_state_q;
  mult_state_e             mult_state_d;
  logic                    is_mult;
  logic                    is_mull;
  logic                    signed_mult;
  logic                    mult_hold;
  logic                    mult_en;
  logic                    a_neg;
  logic                    b_neg;
  logic [15:0]             mac_op_a;
  logic [15:0]             mac_op_b;
  logic                    mac_sign_a;
  logic                    mac_sign_b;
  logic signed [IMD_W-1:0] accum;
  logic signed [IMD_W-1:0] mac_res;
  logic [IMD_W-1:0]        mac_res_d;

  assign is_mult     = (req_i.operator == MD_OP_MULL) || (req_i.operator == MD_OP_MULH);
  assign is_mull     = (req_i.operator == MD_OP_MULL);
  assign signed_mult = req_i.sign.a_signed | req_i.sign.b_signed;
  assign a_neg       = req_i.sign.a_signed & req_i.op_a[XLEN-1];
  assign b_neg       = req_i.sign.b_signed & req_i.op_b[XLEN-1];

  // single 17x17 signed multiply-accumulate truncated to the register width
  assign mac_res = $signed({mac_sign_a, mac_op_a}) * $signed({mac_sign_b, mac_op_b}) + accum;

  always_comb begin
    mac_op_a     = req_i.op_a[15:0];
    mac_op_b     = req_i.op_b[15:0];
    mac_sign_a   = 1'b0;
    mac_sign_b   = 1'b0;
    accum        = '0;
    mac_res_d    = mac_res;
    mult_state_d = mult_state_q;
    valid_o      = 1'b0;
    mult_hold    = 1'b0;
    unique case (mult_state_q)
      ALBL: begin
        mult_state_d = ALBH;
      end
      ALBH: begin
        // al*bh plus the upper half of al*bl
        mac_op_b   = req_i.op_b[31:16];
        mac_sign_b = b_neg;
        accum      = {18'b0, imd0_i[31:16]};
        if (is_mull) begin
          mac_res_d = {2'b0, mac_res[15:0], imd0_i[15:0]};
        end
        mult_state_d = AHBL;
      end
      AHBL: begin
        mac_op_a   = req_i.op_a[31:16];
        mac_sign_a = a_neg;
        if (is_mull) begin
          // low word is complete after merging the two low halves
          accum        = {18'b0, imd0_i[31:16]};
          mac_res_d    = {2'b0, mac_res[15:0], imd0_i[15:0]};
          valid_o      = 1'b1;
          mult_hold    = ~ready_i;
          mult_state_d = ALBL;
        end else begin
          accum        = imd0_i;
          mult_state_d = AHBH;
        end
      end
      AHBH: begin
        mac_op_a   = req_i.op_a[31:16];
        mac_op_b   = req_i.op_b[31:16];
        mac_sign_a = a_neg;
        mac_sign_b = b_neg;
        // shift the middle sum down and sign extend it unless fully unsigned
        accum        = {{(IMD_W-18){signed_mult & imd0_i[IMD_W-1]}}, imd0_i[IMD_W-1:16]};
        valid_o      = 1'b1;
        mult_hold    = ~ready_i;
        mult_state_d = ALBL;
      end
      default: begin
        mult_state_d = ALBL;
      end
    endcase
  end

  assign mult_en    = en_i & is_mult & ~mult_hold;
  assign imd0_wr_o  = '{we: mult_en, data: mac_res_d};
  assign mult_res_o = mac_res_d[XLEN-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mult_state_q <= ALBL;
    end else if (mult_en) begin
      mult_state_q <= mult_state_d;
    end
  end

  // the high-high state belongs to MULH alone
  state_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mult_state_q == AHBH |-> !is_mull);

  // result must wait until it is taken
  valid_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o);

endmodule

`default_nettype wire

/* md_pkg.sv */
`default_nettype none

package md_pkg;

  // operand and result width
  localparam int XLEN = 32;

  // intermediate registers carry two guard bits above the result
  localparam int IMD_W = XLEN + 2;

  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  typedef struct packed {
    logic a_signed;
    logic b_signed;
  } md_sign_t;

  // one complete request as presented by the environment
  typedef struct packed {
    md_op_e          operator;
    md_sign_t        sign;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
  } md_req_t;

  // write request for one intermediate register
  typedef struct packed {
    logic             we;
    logic [IMD_W-1:0] data;
  } imd_wr_t;

endpackage

`default_nettype wire

/* md_shared_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module md_shared_datapath import md_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  md_req_t          req_i,
  input  imd_wr_t          mult_wr_i,
  input  imd_wr_t          div0_wr_i,
  input  imd_wr_t          div1_wr_i,
  input  logic [XLEN:0]    adder_a_i,
  input  logic [XLEN:0]    adder_b_i,
  input  logic [XLEN-1:0]  mult_res_i,
  output logic [IMD_W-1:0] imd0_o,
  output logic [IMD_W-1:0] imd1_o,
  output logic [XLEN+1:0]  adder_sum_o,
  output logic [XLEN-1:0]  result_o
);

  logic             is_div;
  imd_wr_t          imd0_wr;
  logic [IMD_W-1:0] imd0_q;
  logic [IMD_W-1:0] imd1_q;

  // the operator class steers the sharing since the two sequencers never run together
  assign is_div  = (req_i.operator == MD_OP_DIV) || (req_i.operator == MD_OP_REM);
  assign imd0_wr = is_div ? div0_wr_i : mult_wr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imd0_q <= '0;
    end else if (imd0_wr.we) begin
      imd0_q <= imd0_wr.data;
    end
  end

  // only the divider writes the denominator register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imd1_q <= '0;
    end else if (div1_wr_i.we) begin
      imd1_q <= div1_wr_i.data;
    end
  end

  assign imd0_o = imd0_q;
  assign imd1_o = imd1_q;

  // 33-bit adder whose operands carry a forced carry-in in bit 0
  assign adder_sum_o = {1'b0, adder_a_i} + {1'b0, adder_b_i};

  // multiplier result comes straight from the MAC and divider result from register 0
  assign result_o = is_div ? imd0_q[XLEN-1:0] : mult_res_i;

endmodule

`default_nettype wire

/* md_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module md_unit import md_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  md_req_t         req_i,
  input  logic            ready_i,
  output logic [XLEN-1:0] result_o,
  output logic            valid_o
);

  imd_wr_t          mult_wr;
  imd_wr_t          div0_wr;
  imd_wr_t          div1_wr;
  logic [IMD_W-1:0] imd0;
  logic [IMD_W-1:0] imd1;
  logic [XLEN:0]    adder_a;
  logic [XLEN:0]    adder_b;
  logic [XLEN+1:0]  adder_sum;
  logic [XLEN-1:0]  mult_res;
  logic             mult_valid;
  logic             div_valid;

  md_mult_fast u_mult (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (en_i),
    .req_i      (req_i),
    .ready_i    (ready_i),
    .imd0_i     (imd0),
    .imd0_wr_o  (mult_wr),
    .mult_res_o (mult_res),
    .valid_o    (mult_valid)
  );

  md_div_long u_div (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .en_i        (en_i),
    .req_i       (req_i),
    .ready_i     (ready_i),
    .imd0_i      (imd0),
    .imd1_i      (imd1),
    .adder_sum_i (adder_sum),
    .adder_a_o   (adder_a),
    .adder_b_o   (adder_b),
    .imd0_wr_o   (div0_wr),
    .imd1_wr_o   (div1_wr),
    .valid_o     (div_valid)
  );

  md_shared_datapath u_dp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .mult_wr_i   (mult_wr),
    .div0_wr_i   (div0_wr),
    .div1_wr_i   (div1_wr),
    .adder_a_i   (adder_a),
    .adder_b_i   (adder_b),
    .mult_res_i  (mult_res),
    .imd0_o      (imd0),
    .imd1_o      (imd1),
    .adder_sum_o (adder_sum),
    .result_o    (result_o)
  );

  assign valid_o = mult_valid | div_valid;

endmodule

`default_nettype wire

/* md_vectors.txt */
# op: 0 mull, 1 mulh, 2 div, 3 rem; sign: bit 1 a_signed, bit 0 b_signed
# op sign op_a op_b expected, all in hex
0 0 00000007 00000006 0000002a
0 3 ffffffff 00000005 fffffffb
0 3 deadbeef 00000010 eadbeef0
0 0 80000000 80000000 00000000
1 3 ffffffff ffffffff 00000000
1 3 80000000 80000000 40000000
1 3 7fffffff 7fffffff 3fffffff
1 0 ffffffff ffffffff fffffffe
1 0 80000000 00000004 00000002
1 2 ffffffff ffffffff ffffffff
1 2 00000002 80000000 00000001
2 3 00000014 00000006 00000003
3 3 00000014 00000006 00000002
2 3 ffffffec 00000006 fffffffd
3 3 ffffffec 00000006 fffffffe
2 3 80000000 ffffffff 80000000
3 3 80000000 ffffffff 00000000
2 0 ffffffff 00000002 7fffffff
3 0 ffffffff 00000010 0000000f
2 3 00000007 fffffffe fffffffd
2 3 12345678 00000000 ffffffff
3 3 12345678 00000000 12345678

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_md_unit -o sim_md_unit \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_md_unit > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* sources.f */
md_pkg.sv
md_mult_fast.sv
md_div_long.sv
md_shared_datapath.sv
md_unit.sv
tb_md_unit.sv

/* tb_md_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_md_unit import md_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  // worst case per vector is the divide latency plus the longest stall and a margin
  localparam int CYCLES_PER_VECTOR = 37 + 3 + 4;

  typedef struct packed {
    logic [1:0]      op;
    logic [1:0]      sign;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] expected;
  } vector_t;

  logic            clk_i;
  logic            rst_ni;
  logic            en_i;
  logic            ready_i;
  md_req_t         req_i;
  logic [XLEN-1:0] result_o;
  logic            valid_o;

  vector_t vectors[$];
  int      num_vectors;
  int      error_count;
  int      pass_count;
  int      fail_count;
  integer  seed;

  md_unit dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (en_i),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .result_o (result_o),
    .valid_o  (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail at %t: %s expected %h got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  // cycle in which valid_o must rise when the first enabled edge counts as cycle 1
  function automatic int expected_valid_cycle(input logic [1:0] op, input logic [31:0] b);
    case (op)
      2'd0: return 3;
      2'd1: return 4;
      default: return (b == 32'd0) ? 2 : 37;
    endcase
  endfunction

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_sign;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_exp;
    vector_t     v;
    fd = $fopen("md_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open md_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // lines starting with # describe the columns
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h", f_op, f_sign, f_a, f_b, f_exp);
          if (n == 5) begin
            v.op       = f_op[1:0];
            v.sign     = f_sign[1:0];
            v.a        = f_a;
            v.b        = f_b;
            v.expected = f_exp;
            vectors.push_back(v);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_vector(input int idx, input vector_t v);
    int          edges;
    int          stall;
    int          errors_before;
    logic [31:0] held_result;
    errors_before = error_count;
    stall = $unsigned($random(seed)) % 4;
    req_i.operator      = md_op_e'(v.op);
    req_i.sign.a_signed = v.sign[1];
    req_i.sign.b_signed = v.sign[0];
    req_i.op_a          = v.a;
    req_i.op_b          = v.b;
    en_i    = 1'b1;
    ready_i = 1'b0;
    edges   = 0;
    do begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
    end while (!valid_o);
    compare_value("valid cycle", expected_valid_cycle(v.op, v.b), edges + 1);
    compare_value("result_o", v.expected, result_o);
    held_result = result_o;
    // the result has to stay put under back-pressure
    repeat (stall) begin
      @(posedge clk_i);
      @(negedge clk_i);
      compare_value("valid_o", 32'd1, 32'(valid_o));
      compare_value("result_o", held_result, result_o);
    end
    ready_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    en_i    = 1'b0;
    ready_i = 1'b0;
    compare_value("valid_o", 32'd0, 32'(valid_o));
    if (error_count == errors_before) begin
      pass_count++;
      $display("test %0d: op %0d sign %0d a %h b %h stall %0d pass",
               idx, v.op, v.sign, v.a, v.b, stall);
    end else begin
      fail_count++;
      $display("test %0d: op %0d sign %0d a %h b %h stall %0d fail",
               idx, v.op, v.sign, v.a, v.b, stall);
    end
  endtask

  initial begin : main
    $timeformat(-9, 0, " ns", 0);
    rst_ni      = 1'b0;
    en_i        = 1'b0;
    ready_i     = 1'b0;
    req_i       = '0;
    seed        = 32'h6d0a;
    error_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    load_vectors();
    num_vectors = vectors.size();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    if (num_vectors == 0) begin
      $display("no test vectors were read from md_vectors.txt");
      error_count++;
    end else begin
      foreach (vectors[i]) begin
        run_vector(i, vectors[i]);
      end
    end
    $display("vectors passed %0d, failed %0d", pass_count, fail_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    wait (num_vectors > 0);
    #(CLK_PERIOD * (num_vectors * CYCLES_PER_VECTOR + 10));
    $display("the run timed out waiting for valid_o");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
